//--- design/hazardPkg.sv
package hazardPkg;

    ////////////////////
    // Primary opcodes
    ////////////////////
    localparam logic [5:0] opR      = 6'b000000;
    localparam logic [5:0] opOri    = 6'b001101;
    localparam logic [5:0] opLui    = 6'b001111;
    localparam logic [5:0] opLw     = 6'b100011;
    localparam logic [5:0] opSw     = 6'b101011;
    localparam logic [5:0] opBeq    = 6'b000100;
    localparam logic [5:0] opJ      = 6'b000010;
    localparam logic [5:0] opJal    = 6'b000011;
    // Custom branch-and-link, opcode all ones
    localparam logic [5:0] opBltzal = 6'b111111;

    // R-type function codes
    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnJr  = 6'b001000;

    // Link register for jal and bltzal
    localparam logic [4:0] regLink = 5'd31;

    ////////////////////
    // Timing values
    ////////////////////
    // Shared scale for Tuse and Tnew, in cycles
    localparam logic [1:0] tZero = 2'd0;
    localparam logic [1:0] tOne  = 2'd1;
    localparam logic [1:0] tTwo  = 2'd2;

    // Forwarding source for a decode operand
    localparam logic [1:0] fwdNone = 2'b00;
    localparam logic [1:0] fwdE    = 2'b01;
    localparam logic [1:0] fwdM    = 2'b10;

    ////////////////////
    // Instruction views
    ////////////////////
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat;

    // Same 32-bit word, read as R-type or I-type
    typedef union packed {
        rFormat r;
        iFormat i;
    } instrWord;

endpackage

//--- design/useDecoder.sv
`timescale 1ns/1ps

module useDecoder (
    input  hazardPkg::instrWord instrD,
    output logic [4:0]          numUseRs,
    output logic [4:0]          numUseRt,
    output logic [1:0]          tUseRs,
    output logic [1:0]          tUseRt
);
    import hazardPkg::*;

    // Register 0 as source means no use
    always_comb begin
        numUseRs = 5'd0;
        numUseRt = 5'd0;
        tUseRs   = tZero;
        tUseRt   = tZero;

        case (instrD.r.op)
            opR: begin
                case (instrD.r.funct)
                    fnAdd, fnSub: begin
                        // ALU needs both operands in execute
                        numUseRs = instrD.r.rs;
                        numUseRt = instrD.r.rt;
                        tUseRs   = tOne;
                        tUseRt   = tOne;
                    end
                    fnJr: begin
                        // Jump target consumed in decode
                        numUseRs = instrD.r.rs;
                        tUseRs   = tZero;
                    end
                    default: begin
                        numUseRs = 5'd0;
                    end
                endcase
            end

            opOri, opLw: begin
                numUseRs = instrD.i.rs;
                tUseRs   = tOne;
            end

            opSw: begin
                // Base in execute, store data not until memory
                numUseRs = instrD.i.rs;
                numUseRt = instrD.i.rt;
                tUseRs   = tOne;
                tUseRt   = tTwo;
            end

            opBeq: begin
                // Compared in decode
                numUseRs = instrD.i.rs;
                numUseRt = instrD.i.rt;
                tUseRs   = tZero;
                tUseRt   = tZero;
            end

            opBltzal: begin
                numUseRs = instrD.i.rs;
                tUseRs   = tZero;
            end

            // No register sources
            opLui, opJ, opJal: begin
                numUseRs = 5'd0;
            end

            default: begin
                numUseRs = 5'd0;
            end
        endcase
    end

endmodule

//--- design/newDecoder.sv
`timescale 1ns/1ps

module newDecoder (
    input  hazardPkg::instrWord instrE,
    output logic [4:0]          numNewE,
    output logic [1:0]          tNewE
);
    import hazardPkg::*;

    // Destination and cycles left until the result exists
    always_comb begin
        numNewE = 5'd0;
        tNewE   = tZero;

        case (instrE.r.op)
            opR: begin
                if (instrE.r.funct == fnAdd || instrE.r.funct == fnSub) begin
                    numNewE = instrE.r.rd;
                    tNewE   = tOne;
                end
            end

            opOri, opLui: begin
                numNewE = instrE.i.rt;
                tNewE   = tOne;
            end

            opLw: begin
                // Data only after the memory stage
                numNewE = instrE.i.rt;
                tNewE   = tTwo;
            end

            opJal, opBltzal: begin
                // Return address already known
                numNewE = regLink;
                tNewE   = tZero;
            end

            default: begin
                numNewE = 5'd0;
                tNewE   = tZero;
            end
        endcase
    end

endmodule

//--- design/producerTrack.sv
`timescale 1ns/1ps

module producerTrack (
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] numNewE,
    input  logic [1:0] tNewE,
    input  logic       regWriteE,
    output logic [4:0] numNewM,
    output logic [1:0] tNewM,
    output logic       regWriteM
);
    import hazardPkg::*;

    logic [1:0] tNewAged;

    // One cycle closer, saturating at zero
    always_comb begin
        if (tNewE == tZero) begin
            tNewAged = tZero;
        end else begin
            tNewAged = tNewE - tOne;
        end
    end

    ////////////////////
    // Memory-stage copy
    ////////////////////
    // Loads every cycle, the bubble on stall moves the producer along
    always_ff @(posedge clk) begin
        if (reset) begin
            numNewM   <= 5'd0;
            tNewM     <= tZero;
            regWriteM <= 1'b0;
        end else begin
            numNewM   <= numNewE;
            tNewM     <= tNewAged;
            regWriteM <= regWriteE;
        end
    end

endmodule

//--- design/stallLogic.sv
`timescale 1ns/1ps

module stallLogic (
    input  logic [4:0] numUseRs,
    input  logic [4:0] numUseRt,
    input  logic [1:0] tUseRs,
    input  logic [1:0] tUseRt,
    input  logic [4:0] numNewE,
    input  logic [1:0] tNewE,
    input  logic       regWriteE,
    input  logic [4:0] numNewM,
    input  logic [1:0] tNewM,
    input  logic       regWriteM,
    output logic       stall
);

    // Consumer needs the value before the producer has it
    function automatic logic tooEarly(
        input logic [4:0] numUse,
        input logic [1:0] tUse,
        input logic [4:0] numNew,
        input logic [1:0] tNew,
        input logic       regWrite
    );
        logic match;
        match    = (numUse != 5'd0) && (numUse == numNew) && regWrite;
        tooEarly = match && (tUse < tNew);
    endfunction

    logic rsHazardE;
    logic rsHazardM;
    logic rtHazardE;
    logic rtHazardM;

    assign rsHazardE = tooEarly(numUseRs, tUseRs, numNewE, tNewE, regWriteE);
    assign rsHazardM = tooEarly(numUseRs, tUseRs, numNewM, tNewM, regWriteM);
    assign rtHazardE = tooEarly(numUseRt, tUseRt, numNewE, tNewE, regWriteE);
    assign rtHazardM = tooEarly(numUseRt, tUseRt, numNewM, tNewM, regWriteM);

    assign stall = rsHazardE | rsHazardM | rtHazardE | rtHazardM;

endmodule

//--- design/forwardSelect.sv
`timescale 1ns/1ps

module forwardSelect (
    input  logic [4:0] numUseRs,
    input  logic [4:0] numUseRt,
    input  logic [4:0] numNewE,
    input  logic [1:0] tNewE,
    input  logic       regWriteE,
    input  logic [4:0] numNewM,
    input  logic [1:0] tNewM,
    input  logic       regWriteM,
    output logic [1:0] fwdRsD,
    output logic [1:0] fwdRtD
);
    import hazardPkg::*;

    // Execute first, it holds the younger result
    function automatic logic [1:0] pickSource(
        input logic [4:0] numUse,
        input logic [4:0] numE,
        input logic [1:0] tE,
        input logic       weE,
        input logic [4:0] numM,
        input logic [1:0] tM,
        input logic       weM
    );
        logic readyE;
        logic readyM;
        readyE = (numUse != 5'd0) && (numUse == numE) && weE && (tE == tZero);
        readyM = (numUse != 5'd0) && (numUse == numM) && weM && (tM == tZero);
        if (readyE) begin
            pickSource = fwdE;
        end else if (readyM) begin
            pickSource = fwdM;
        end else begin
            pickSource = fwdNone;
        end
    endfunction

    ////////////////////
    // Per-operand select
    ////////////////////
    assign fwdRsD = pickSource(numUseRs, numNewE, tNewE, regWriteE,
                               numNewM, tNewM, regWriteM);
    assign fwdRtD = pickSource(numUseRt, numNewE, tNewE, regWriteE,
                               numNewM, tNewM, regWriteM);

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instrD,
    input  logic [31:0] instrE,
    input  logic        regWriteE,
    output logic        pcWrite,
    output logic        ifIdEn,
    output logic        idExClr,
    output logic [1:0]  fwdRsD,
    output logic [1:0]  fwdRtD,
    output logic [4:0]  numUseRsD,
    output logic [4:0]  numUseRtD
);

    logic [4:0] numUseRs;
    logic [4:0] numUseRt;
    logic [1:0] tUseRs;
    logic [1:0] tUseRt;
    logic [4:0] numNewE;
    logic [1:0] tNewE;
    logic [4:0] numNewM;
    logic [1:0] tNewM;
    logic       regWriteM;
    logic       stall;

    ////////////////////
    // Decode and execute
    ////////////////////
    useDecoder u_useDecoder (
        .instrD   (instrD),
        .numUseRs (numUseRs),
        .numUseRt (numUseRt),
        .tUseRs   (tUseRs),
        .tUseRt   (tUseRt)
    );

    newDecoder u_newDecoder (
        .instrE  (instrE),
        .numNewE (numNewE),
        .tNewE   (tNewE)
    );

    // Producer one stage later
    producerTrack u_producerTrack (
        .clk       (clk),
        .reset     (reset),
        .numNewE   (numNewE),
        .tNewE     (tNewE),
        .regWriteE (regWriteE),
        .numNewM   (numNewM),
        .tNewM     (tNewM),
        .regWriteM (regWriteM)
    );

    ////////////////////
    // Decisions
    ////////////////////
    stallLogic u_stallLogic (
        .numUseRs  (numUseRs),
        .numUseRt  (numUseRt),
        .tUseRs    (tUseRs),
        .tUseRt    (tUseRt),
        .numNewE   (numNewE),
        .tNewE     (tNewE),
        .regWriteE (regWriteE),
        .numNewM   (numNewM),
        .tNewM     (tNewM),
        .regWriteM (regWriteM),
        .stall     (stall)
    );

    forwardSelect u_forwardSelect (
        .numUseRs  (numUseRs),
        .numUseRt  (numUseRt),
        .numNewE   (numNewE),
        .tNewE     (tNewE),
        .regWriteE (regWriteE),
        .numNewM   (numNewM),
        .tNewM     (tNewM),
        .regWriteM (regWriteM),
        .fwdRsD    (fwdRsD),
        .fwdRtD    (fwdRtD)
    );

    // Freeze fetch and decode, bubble into execute
    assign pcWrite = ~stall;
    assign ifIdEn  = ~stall;
    assign idExClr = stall;

    // Source numbers for the datapath forwarding muxes
    assign numUseRsD = numUseRs;
    assign numUseRtD = numUseRt;

endmodule

//--- verif/hazardUnit_chk.sv
`timescale 1ns/1ps

module hazardUnit_chk (
    input logic clk,
    input logic reset,
    input logic regWriteE,
    input logic pcWrite,
    input logic ifIdEn,
    input logic idExClr
);

    ////////////////////
    // Control pairing
    ////////////////////
    // A bubble goes into execute exactly when fetch freezes
    bubbleMatchesFreeze: assert property (@(posedge clk) idExClr == !pcWrite)
        else $error("idExClr is not the inverse of pcWrite");

    fetchDecodeTogether: assert property (@(posedge clk) pcWrite == ifIdEn)
        else $error("pcWrite and ifIdEn disagree");

    // Memory stage empty right after reset, only execute could stall
    cleanStart: assert property (
        @(posedge clk) $past(reset) && !reset && !regWriteE |-> pcWrite
    ) else $error("stall in the first cycle after reset without a write in execute");

endmodule

//--- verif/hazardUnitTb.sv
`timescale 1ns/1ps

module hazardUnitTb;
    import hazardPkg::*;

    localparam int maxRows      = 32;
    localparam int resetTimeout = 100;

    logic        clk;
    logic        reset;
    logic [31:0] instrD;
    logic [31:0] instrE;
    logic        regWriteE;
    logic        pcWrite;
    logic        ifIdEn;
    logic        idExClr;
    logic [1:0]  fwdRsD;
    logic [1:0]  fwdRtD;
    logic [4:0]  numUseRsD;
    logic [4:0]  numUseRtD;

    ////////////////////
    // Stimulus table
    ////////////////////
    logic [31:0] tblInstrD [maxRows];
    logic [31:0] tblInstrE [maxRows];
    logic        tblWrite  [maxRows];
    logic        tblStall  [maxRows];
    logic [1:0]  tblFwdRs  [maxRows];
    logic [1:0]  tblFwdRt  [maxRows];
    logic [4:0]  tblUseRs  [maxRows];
    logic [4:0]  tblUseRt  [maxRows];
    string       tblName   [maxRows];
    int          rowCount;
    int          passCount;
    int          failCount;
    int          waitCycles;

    hazardUnit u_hazardUnit (
        .clk       (clk),
        .reset     (reset),
        .instrD    (instrD),
        .instrE    (instrE),
        .regWriteE (regWriteE),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr),
        .fwdRsD    (fwdRsD),
        .fwdRtD    (fwdRtD),
        .numUseRsD (numUseRsD),
        .numUseRtD (numUseRtD)
    );

    bind hazardUnit hazardUnit_chk u_hazardUnitChk (
        .clk       (clk),
        .reset     (reset),
        .regWriteE (regWriteE),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
    end

    // Instruction word builders
    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] funct);
        return {opR, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addRow(input logic [31:0] d, input logic [31:0] e, input logic we,
                          input logic expStall, input logic [1:0] expRs,
                          input logic [1:0] expRt, input logic [4:0] expUseRs,
                          input logic [4:0] expUseRt, input string name);
        tblInstrD[rowCount] = d;
        tblInstrE[rowCount] = e;
        tblWrite[rowCount]  = we;
        tblStall[rowCount]  = expStall;
        tblFwdRs[rowCount]  = expRs;
        tblFwdRt[rowCount]  = expRt;
        tblUseRs[rowCount]  = expUseRs;
        tblUseRt[rowCount]  = expUseRt;
        tblName[rowCount]   = name;
        rowCount++;
    endtask

    // Each row sees the previous row's execute content in memory
    task automatic buildTable();
        logic [31:0] nop;
        logic [31:0] lwR5;
        logic [31:0] addUsesR5;
        logic [31:0] beqUsesR5;
        logic [31:0] jal;
        logic [31:0] jrR31;
        logic [31:0] swBaseR5;
        logic [31:0] swDataR5;
        logic [31:0] oriToR0;
        logic [31:0] beqR0;
        logic [31:0] luiR5;
        logic [31:0] jump;
        logic [31:0] addR7R8;
        logic [31:0] addToR4;
        logic [31:0] bltzalR4;
        logic [31:0] bltzalR0;
        logic [31:0] addR31R31;
        logic [31:0] addR31R2;
        nop       = 32'd0;
        lwR5      = encodeI(opLw, 5'd1, 5'd5, 16'd0);
        addUsesR5 = encodeR(5'd5, 5'd2, 5'd6, fnAdd);
        beqUsesR5 = encodeI(opBeq, 5'd5, 5'd3, 16'd4);
        jal       = {opJal, 26'h0000040};
        jrR31     = encodeR(5'd31, 5'd0, 5'd0, fnJr);
        swBaseR5  = encodeI(opSw, 5'd5, 5'd3, 16'd0);
        swDataR5  = encodeI(opSw, 5'd1, 5'd5, 16'd4);
        oriToR0   = encodeI(opOri, 5'd1, 5'd0, 16'h00ff);
        beqR0     = encodeI(opBeq, 5'd0, 5'd0, 16'd8);
        luiR5     = encodeI(opLui, 5'd0, 5'd5, 16'h1234);
        jump      = {opJ, 26'h0000100};
        addR7R8   = encodeR(5'd7, 5'd8, 5'd9, fnAdd);
        addToR4   = encodeR(5'd1, 5'd2, 5'd4, fnSub);
        bltzalR4  = encodeI(opBltzal, 5'd4, 5'd0, 16'd2);
        bltzalR0  = encodeI(opBltzal, 5'd0, 5'd0, 16'd2);
        addR31R31 = encodeR(5'd31, 5'd31, 5'd10, fnAdd);
        addR31R2  = encodeR(5'd31, 5'd2, 5'd10, fnAdd);
        rowCount  = 0;
        addRow(nop, nop, 1'b0, 1'b0, fwdNone, fwdNone, 5'd0, 5'd0, "nop after reset");
        addRow(addUsesR5, lwR5, 1'b1, 1'b1, fwdNone, fwdNone, 5'd5, 5'd2, "load-use add");
        addRow(addUsesR5, nop, 1'b0, 1'b0, fwdNone, fwdNone, 5'd5, 5'd2, "add with load in M");
        addRow(beqUsesR5, lwR5, 1'b1, 1'b1, fwdNone, fwdNone, 5'd5, 5'd3, "load-use beq");
        addRow(beqUsesR5, nop, 1'b0, 1'b1, fwdNone, fwdNone, 5'd5, 5'd3, "beq with load in M");
        addRow(beqUsesR5, nop, 1'b0, 1'b0, fwdNone, fwdNone, 5'd5, 5'd3, "beq after load left");
        addRow(jrR31, jal, 1'b1, 1'b0, fwdE, fwdNone, 5'd31, 5'd0, "jr from jal in E");
        addRow(jrR31, nop, 1'b0, 1'b0, fwdM, fwdNone, 5'd31, 5'd0, "jr from jal in M");
        addRow(swBaseR5, lwR5, 1'b1, 1'b1, fwdNone, fwdNone, 5'd5, 5'd3, "sw base load-use");
        addRow(swDataR5, lwR5, 1'b1, 1'b0, fwdNone, fwdNone, 5'd1, 5'd5, "sw data after load");
        addRow(beqR0, oriToR0, 1'b1, 1'b0, fwdNone, fwdNone, 5'd0, 5'd0, "destination r0");
        addRow(addUsesR5, lwR5, 1'b0, 1'b0, fwdNone, fwdNone, 5'd5, 5'd2, "write enable low");
        addRow(luiR5, lwR5, 1'b1, 1'b0, fwdNone, fwdNone, 5'd0, 5'd0, "lui in decode");
        addRow(jump, lwR5, 1'b1, 1'b0, fwdNone, fwdNone, 5'd0, 5'd0, "j in decode");
        addRow(addR7R8, lwR5, 1'b1, 1'b0, fwdNone, fwdNone, 5'd7, 5'd8, "mismatched registers");
        addRow(bltzalR4, addToR4, 1'b1, 1'b1, fwdNone, fwdNone, 5'd4, 5'd0, "bltzal on sub in E");
        addRow(bltzalR4, nop, 1'b0, 1'b0, fwdM, fwdNone, 5'd4, 5'd0, "bltzal with sub in M");
        addRow(addR31R31, bltzalR0, 1'b1, 1'b0, fwdE, fwdE, 5'd31, 5'd31, "add from bltzal in E");
        addRow(addR31R31, jal, 1'b1, 1'b0, fwdE, fwdE, 5'd31, 5'd31, "E priority over M");
        addRow(addR31R2, nop, 1'b0, 1'b0, fwdM, fwdNone, 5'd31, 5'd2, "add from jal in M");
        addRow(nop, nop, 1'b0, 1'b0, fwdNone, fwdNone, 5'd0, 5'd0, "idle");
    endtask

    ////////////////////
    // Row driver
    ////////////////////
    task automatic applyRow(input int idx);
        logic rowOk;
        rowOk = 1'b1;
        @(posedge clk);
        #1;
        instrD    = tblInstrD[idx];
        instrE    = tblInstrE[idx];
        regWriteE = tblWrite[idx];
        // Sample just before the next edge
        #6;
        assert (idExClr === tblStall[idx]) else begin
            $display("Fail at %0t: %s idExClr %b expected %b",
                     $time, tblName[idx], idExClr, tblStall[idx]);
            rowOk = 1'b0;
        end
        assert (pcWrite === !tblStall[idx]) else begin
            $display("Fail at %0t: %s pcWrite %b", $time, tblName[idx], pcWrite);
            rowOk = 1'b0;
        end
        assert (ifIdEn === !tblStall[idx]) else begin
            $display("Fail at %0t: %s ifIdEn %b", $time, tblName[idx], ifIdEn);
            rowOk = 1'b0;
        end
        assert (fwdRsD === tblFwdRs[idx]) else begin
            $display("Fail at %0t: %s fwdRsD %b expected %b",
                     $time, tblName[idx], fwdRsD, tblFwdRs[idx]);
            rowOk = 1'b0;
        end
        assert (fwdRtD === tblFwdRt[idx]) else begin
            $display("Fail at %0t: %s fwdRtD %b expected %b",
                     $time, tblName[idx], fwdRtD, tblFwdRt[idx]);
            rowOk = 1'b0;
        end
        assert (numUseRsD === tblUseRs[idx]) else begin
            $display("Fail at %0t: %s numUseRsD %0d expected %0d",
                     $time, tblName[idx], numUseRsD, tblUseRs[idx]);
            rowOk = 1'b0;
        end
        assert (numUseRtD === tblUseRt[idx]) else begin
            $display("Fail at %0t: %s numUseRtD %0d expected %0d",
                     $time, tblName[idx], numUseRtD, tblUseRt[idx]);
            rowOk = 1'b0;
        end
        if (rowOk) begin
            passCount++;
            $display("row %0d %s: ok", idx, tblName[idx]);
        end else begin
            failCount++;
            $display("row %0d %s: wrong", idx, tblName[idx]);
        end
    endtask

    initial begin
        instrD     = 32'd0;
        instrE     = 32'd0;
        regWriteE  = 1'b0;
        passCount  = 0;
        failCount  = 0;
        waitCycles = 0;
        buildTable();
        while (reset !== 1'b0 && waitCycles < resetTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (reset !== 1'b0) begin
            $display("timeout: reset was never released");
            $display("tests failed");
        end else begin
            for (int i = 0; i < rowCount; i++) begin
                applyRow(i);
            end
            $display("passed %0d, failed %0d", passCount, failCount);
            if (failCount == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
        end
        $finish;
    end

endmodule

//--- hazardUnit.f
design/hazardPkg.sv
design/useDecoder.sv
design/newDecoder.sv
design/producerTrack.sv
design/stallLogic.sv
design/forwardSelect.sv
design/hazardUnit.sv
verif/hazardUnit_chk.sv
verif/hazardUnitTb.sv

//--- Makefile
TOP = hazardUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f hazardUnit.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f hazardUnit.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
